/* project.f */
cache_pkg.sv
tag_sram.sv
l1_tag_store.sv
l2_tag_store.sv
tag_apb_regs.sv
cache_tag_top.sv
tb_cache_tag_top.sv

/* Makefile */
# Verilator build and run of the cache tag store testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, fail on a reported error"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --assert --top-module tb_cache_tag_top -f project.f --Mdir obj_dir
	./obj_dir/Vtb_cache_tag_top > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Test failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* tb_cache_tag_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache_tag_top;

    // about twice the cycles the six tests take together
    localparam int MAX_CYCLES = 4000;

    logic                  clk;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    cache_pkg::apb_addr_t  paddr;
    cache_pkg::apb_data_t  pwdata;
    cache_pkg::apb_data_t  prdata;
    logic                  pready;
    logic                  pslverr;

    // expected response of the transfer on the bus
    cache_pkg::apb_data_t  exp_rdata;
    logic                  exp_err;

    // reference model of staging registers and arrays
    cache_pkg::l2_index_t  m_index;
    cache_pkg::l1_tag_t    m_tag;
    cache_pkg::l1_tag_t    m_l1_tag [cache_pkg::L1_SETS][cache_pkg::L1_WAYS];
    logic                  m_lru    [cache_pkg::L1_SETS];
    cache_pkg::l2_tag_t    m_l2_tag [cache_pkg::L2_SETS][cache_pkg::L2_WAYS];
    cache_pkg::plru_t      m_plru   [cache_pkg::L2_SETS];

    logic [31:0]           rng_state;
    int                    cycles = 0;
    int                    fail_cnt = 0;
    int                    fail_base = 0;
    int                    tests_ok = 0;
    int                    tests_bad = 0;
    cache_pkg::l2_index_t  touched [$];

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    cache_tag_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // error response in every access cycle
    a_slverr : assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable) |-> (pslverr == exp_err))
    else begin
        fail_cnt++;
        $display("CHECK FAILED at %0t: pslverr %0b for addr 0x%02h, expected %0b",
                 $time, $sampled(pslverr), $sampled(paddr), $sampled(exp_err));
    end

    // read data against the model
    a_rdata : assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable && !pwrite && !exp_err) |-> (prdata == exp_rdata))
    else begin
        fail_cnt++;
        $display("CHECK FAILED at %0t: read 0x%02h returned 0x%08h, expected 0x%08h",
                 $time, $sampled(paddr), $sampled(prdata), $sampled(exp_rdata));
    end

    // no wait states, no stray error outside an access
    a_ready : assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable) |-> pready)
    else begin
        fail_cnt++;
        $display("CHECK FAILED at %0t: pready low in access cycle", $time);
    end

    a_idle_err : assert property (@(posedge clk) disable iff (!rst_n)
        !(psel && penable) |-> !pslverr)
    else begin
        fail_cnt++;
        $display("CHECK FAILED at %0t: pslverr high outside an access cycle", $time);
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // register map decode as the bus sees it
    function automatic logic slave_error(input logic wr, input cache_pkg::apb_addr_t addr,
                                         input cache_pkg::apb_data_t data);
        logic mapped;
        logic ro;
        mapped = 1'b1;
        ro     = 1'b1;
        case (addr)
            cache_pkg::REG_INDEX, cache_pkg::REG_TAG_WD, cache_pkg::REG_FILL: ro = 1'b0;
            cache_pkg::REG_L1_TAG0, cache_pkg::REG_L1_TAG1, cache_pkg::REG_L2_TAG0,
            cache_pkg::REG_L2_TAG1, cache_pkg::REG_L2_TAG2, cache_pkg::REG_L2_TAG3,
            cache_pkg::REG_REPL: ro = 1'b1;
            default: mapped = 1'b0;
        endcase
        // l1 fill to way 2 or 3
        if (wr && addr == cache_pkg::REG_FILL && !data[0] && data[2:1] > 2'd1) begin
            return 1'b1;
        end
        return !mapped || (wr && ro);
    endfunction

    function automatic cache_pkg::apb_data_t expected_rdata(input cache_pkg::apb_addr_t addr);
        cache_pkg::l1_index_t i1;
        i1 = m_index[7:0];
        case (addr)
            cache_pkg::REG_INDEX:   return {23'd0, m_index};
            cache_pkg::REG_TAG_WD:  return {11'd0, m_tag};
            cache_pkg::REG_L1_TAG0: return {11'd0, m_l1_tag[i1][0]};
            cache_pkg::REG_L1_TAG1: return {11'd0, m_l1_tag[i1][1]};
            cache_pkg::REG_L2_TAG0: return {13'd0, m_l2_tag[m_index][0]};
            cache_pkg::REG_L2_TAG1: return {13'd0, m_l2_tag[m_index][1]};
            cache_pkg::REG_L2_TAG2: return {13'd0, m_l2_tag[m_index][2]};
            cache_pkg::REG_L2_TAG3: return {13'd0, m_l2_tag[m_index][3]};
            // tree bits 3..1, lru in bit 0
            cache_pkg::REG_REPL:    return {28'd0, m_plru[m_index], m_lru[i1]};
            default:                return '0;
        endcase
    endfunction

    // model update for an accepted write
    task automatic model_write(input cache_pkg::apb_addr_t addr, input cache_pkg::apb_data_t data);
        cache_pkg::l1_index_t i1;
        cache_pkg::way_t      w;
        cache_pkg::plru_t     t;
        i1 = m_index[7:0];
        w  = data[2:1];
        t  = m_plru[m_index];
        if (addr == cache_pkg::REG_INDEX) begin
            m_index = data[8:0];
        end else if (addr == cache_pkg::REG_TAG_WD) begin
            m_tag = data[20:0];
        end else if (addr == cache_pkg::REG_FILL && !data[0]) begin
            m_l1_tag[i1][w[0]] = m_tag;
            // lru names the way that was not just filled
            m_lru[i1] = !w[0];
        end else if (addr == cache_pkg::REG_FILL) begin
            m_l2_tag[m_index][w] = m_tag[18:0];
            case (w)
                2'd0: m_plru[m_index] = {t[2], 1'b1, 1'b1};
                2'd1: m_plru[m_index] = {t[2], 1'b0, 1'b1};
                2'd2: m_plru[m_index] = {1'b1, t[1], 1'b0};
                default: m_plru[m_index] = {1'b0, t[1], 1'b0};
            endcase
        end
    endtask

    task automatic apb_write(input cache_pkg::apb_addr_t addr, input cache_pkg::apb_data_t data);
        logic err;
        err = slave_error(1'b1, addr, data);
        // setup
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        exp_err <= err;
        // access until pready
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        while (pready !== 1'b1) begin
            @(posedge clk);
        end
        psel    <= 1'b0;
        penable <= 1'b0;
        if (!err) begin
            model_write(addr, data);
        end
    endtask

    task automatic apb_read(input cache_pkg::apb_addr_t addr);
        cache_pkg::apb_data_t want_data;
        logic                 want_err;
        want_data = expected_rdata(addr);
        want_err  = slave_error(1'b0, addr, '0);
        @(posedge clk);
        psel      <= 1'b1;
        penable   <= 1'b0;
        pwrite    <= 1'b0;
        paddr     <= addr;
        exp_rdata <= want_data;
        exp_err   <= want_err;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        while (pready !== 1'b1) begin
            @(posedge clk);
        end
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic fill(input logic level, input cache_pkg::way_t way,
                        input cache_pkg::l2_index_t idx, input cache_pkg::l1_tag_t tag);
        apb_write(cache_pkg::REG_INDEX, {23'd0, idx});
        apb_write(cache_pkg::REG_TAG_WD, {11'd0, tag});
        apb_write(cache_pkg::REG_FILL, {29'd0, way, level});
    endtask

    // every tag and the replacement bits of one index
    task automatic read_set(input cache_pkg::l2_index_t idx);
        apb_write(cache_pkg::REG_INDEX, {23'd0, idx});
        apb_read(cache_pkg::REG_L1_TAG0);
        apb_read(cache_pkg::REG_L1_TAG1);
        apb_read(cache_pkg::REG_L2_TAG0);
        apb_read(cache_pkg::REG_L2_TAG1);
        apb_read(cache_pkg::REG_L2_TAG2);
        apb_read(cache_pkg::REG_L2_TAG3);
        apb_read(cache_pkg::REG_REPL);
    endtask

    task automatic report_test(input string name);
        // let the last access-cycle checks settle
        @(posedge clk);
        if (fail_cnt == fail_base) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d check(s) failed", name, fail_cnt - fail_base);
        end
        fail_base = fail_cnt;
    endtask

    task automatic staging_readback();
        logic [31:0] r;
        // reset values first
        apb_read(cache_pkg::REG_INDEX);
        apb_read(cache_pkg::REG_TAG_WD);
        apb_write(cache_pkg::REG_INDEX, 32'hffff_ffff);
        apb_read(cache_pkg::REG_INDEX);
        apb_write(cache_pkg::REG_TAG_WD, 32'hffff_ffff);
        apb_read(cache_pkg::REG_TAG_WD);
        repeat (4) begin
            r = next_rand();
            apb_write(cache_pkg::REG_INDEX, r);
            apb_read(cache_pkg::REG_INDEX);
            r = next_rand();
            apb_write(cache_pkg::REG_TAG_WD, r);
            apb_read(cache_pkg::REG_TAG_WD);
        end
        // fill command reads as zero
        apb_read(cache_pkg::REG_FILL);
        report_test("staging registers");
    endtask

    task automatic l1_fill_sequence();
        logic [31:0] r;
        r = next_rand();
        fill(1'b0, 2'd0, r[8:0], cache_pkg::l1_tag_t'(next_rand()));
        read_set(r[8:0]);
        fill(1'b0, 2'd1, r[8:0], cache_pkg::l1_tag_t'(next_rand()));
        read_set(r[8:0]);
        report_test("l1 fills");
    endtask

    task automatic l1_lru_toggle();
        logic [31:0] r;
        r = next_rand();
        apb_write(cache_pkg::REG_INDEX, {23'd0, r[8:0]});
        apb_read(cache_pkg::REG_REPL);
        // alternating ways, then a repeat of way 1
        fill(1'b0, 2'd0, r[8:0], 21'h0a5a5);
        apb_read(cache_pkg::REG_REPL);
        fill(1'b0, 2'd1, r[8:0], 21'h15a5a);
        apb_read(cache_pkg::REG_REPL);
        fill(1'b0, 2'd0, r[8:0], 21'h1ffff);
        apb_read(cache_pkg::REG_REPL);
        fill(1'b0, 2'd1, r[8:0], 21'h00001);
        apb_read(cache_pkg::REG_REPL);
        fill(1'b0, 2'd1, r[8:0], 21'h00002);
        apb_read(cache_pkg::REG_REPL);
        report_test("l1 lru");
    endtask

    task automatic l2_fill_plru();
        logic [31:0]      r;
        logic [31:0]      t;
        cache_pkg::way_t  ways [$];
        cache_pkg::way_t  w;
        int               pos;
        r    = next_rand();
        ways = '{2'd0, 2'd1, 2'd2, 2'd3};
        // each way once in a random order
        while (ways.size() > 0) begin
            t   = next_rand();
            pos = int'(t % 32'(ways.size()));
            w   = ways[pos];
            ways.delete(pos);
            t = next_rand();
            fill(1'b1, w, r[8:0], t[20:0]);
            apb_read(cache_pkg::REG_L2_TAG0 + {4'd0, w, 2'b00});
            apb_read(cache_pkg::REG_REPL);
        end
        read_set(r[8:0]);
        report_test("l2 fills and plru");
    endtask

    task automatic index_isolation();
        logic [31:0]     r;
        logic [31:0]     t;
        cache_pkg::way_t w;
        repeat (32) begin
            r = next_rand();
            t = next_rand();
            // l1 takes only ways 0 and 1
            w = r[9] ? r[11:10] : {1'b0, r[10]};
            fill(r[9], w, r[8:0], t[20:0]);
            touched.push_back(r[8:0]);
        end
        // two indices that alias in l1 only
        r = next_rand();
        fill(1'b0, 2'd0, {1'b0, r[7:0]}, 21'h111111);
        fill(1'b1, 2'd1, {1'b0, r[7:0]}, 21'h011111);
        fill(1'b0, 2'd0, {1'b1, r[7:0]}, 21'h022222);
        fill(1'b1, 2'd1, {1'b1, r[7:0]}, 21'h122222);
        touched.push_back({1'b0, r[7:0]});
        touched.push_back({1'b1, r[7:0]});
        foreach (touched[k]) begin
            read_set(touched[k]);
        end
        report_test("index isolation");
    endtask

    task automatic error_responses();
        logic [31:0] r;
        r = next_rand();
        fill(1'b0, 2'd1, r[8:0], 21'h0c0ffe);
        fill(1'b1, 2'd2, r[8:0], 21'h05eed5);
        apb_read(8'h3c);
        apb_write(8'h3c, 32'h0000_0001);
        apb_write(cache_pkg::REG_L1_TAG0, next_rand());
        apb_write(cache_pkg::REG_REPL, 32'hffff_ffff);
        // l1 fill to way 2 and way 3
        apb_write(cache_pkg::REG_FILL, 32'h0000_0004);
        apb_write(cache_pkg::REG_FILL, 32'h0000_0006);
        read_set(r[8:0]);
        report_test("error responses");
    endtask

    initial begin
        rng_state = 32'h2c1e_262b;
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        exp_rdata = '0;
        exp_err   = 1'b0;
        // arrays start at zero, like the tag srams
        m_index   = '0;
        m_tag     = '0;
        m_l1_tag  = '{default: '0};
        m_lru     = '{default: 1'b0};
        m_l2_tag  = '{default: '0};
        m_plru    = '{default: '0};

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        staging_readback();
        l1_fill_sequence();
        l1_lru_toggle();
        l2_fill_plru();
        index_isolation();
        error_responses();

        $display("summary: %0d tests clean, %0d tests with errors, %0d failed checks",
                 tests_ok, tests_bad, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cache_tag_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tag_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  cache_pkg::apb_addr_t  paddr,
    input  cache_pkg::apb_data_t  pwdata,
    output cache_pkg::apb_data_t  prdata,
    output logic                  pready,
    output logic                  pslverr
);

    // register block to tag stores
    cache_pkg::l1_index_t           l1_index;
    cache_pkg::l2_index_t           l2_index;
    cache_pkg::l1_tag_t             l1_tag_wd;
    cache_pkg::l2_tag_t             l2_tag_wd;
    logic [cache_pkg::L1_WAYS-1:0]  l1_we;
    logic [cache_pkg::L2_WAYS-1:0]  l2_we;

    // tag stores back to register block
    cache_pkg::l1_tag_t             l1_tag0_rd;
    cache_pkg::l1_tag_t             l1_tag1_rd;
    logic                           lru;
    cache_pkg::l2_tag_t             l2_tag0_rd;
    cache_pkg::l2_tag_t             l2_tag1_rd;
    cache_pkg::l2_tag_t             l2_tag2_rd;
    cache_pkg::l2_tag_t             l2_tag3_rd;
    cache_pkg::plru_t               plru;

    // apb slave, staging and fill decode
    tag_apb_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .l1_index   (l1_index),
        .l2_index   (l2_index),
        .l1_tag_wd  (l1_tag_wd),
        .l2_tag_wd  (l2_tag_wd),
        .l1_we      (l1_we),
        .l2_we      (l2_we),
        .l1_tag0_rd (l1_tag0_rd),
        .l1_tag1_rd (l1_tag1_rd),
        .lru        (lru),
        .l2_tag0_rd (l2_tag0_rd),
        .l2_tag1_rd (l2_tag1_rd),
        .l2_tag2_rd (l2_tag2_rd),
        .l2_tag3_rd (l2_tag3_rd),
        .plru       (plru)
    );

    // 2-way l1 tags and lru
    l1_tag_store u_l1 (
        .clk     (clk),
        .index   (l1_index),
        .we      (l1_we),
        .tag_wd  (l1_tag_wd),
        .tag0_rd (l1_tag0_rd),
        .tag1_rd (l1_tag1_rd),
        .lru     (lru)
    );

    // 4-way l2 tags and tree plru
    l2_tag_store u_l2 (
        .clk     (clk),
        .index   (l2_index),
        .we      (l2_we),
        .tag_wd  (l2_tag_wd),
        .tag0_rd (l2_tag0_rd),
        .tag1_rd (l2_tag1_rd),
        .tag2_rd (l2_tag2_rd),
        .tag3_rd (l2_tag3_rd),
        .plru    (plru)
    );

endmodule

`default_nettype wire

/* tag_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_apb_regs (
    input  logic                           clk,
    input  logic                           rst_n,
    // apb slave
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  cache_pkg::apb_addr_t           paddr,
    input  cache_pkg::apb_data_t           pwdata,
    output cache_pkg::apb_data_t           prdata,
    output logic                           pready,
    output logic                           pslverr,
    // towards the tag stores
    output cache_pkg::l1_index_t           l1_index,
    output cache_pkg::l2_index_t           l2_index,
    output cache_pkg::l1_tag_t             l1_tag_wd,
    output cache_pkg::l2_tag_t             l2_tag_wd,
    output logic [cache_pkg::L1_WAYS-1:0]  l1_we,
    output logic [cache_pkg::L2_WAYS-1:0]  l2_we,
    // read back from the tag stores
    input  cache_pkg::l1_tag_t             l1_tag0_rd,
    input  cache_pkg::l1_tag_t             l1_tag1_rd,
    input  logic                           lru,
    input  cache_pkg::l2_tag_t             l2_tag0_rd,
    input  cache_pkg::l2_tag_t             l2_tag1_rd,
    input  cache_pkg::l2_tag_t             l2_tag2_rd,
    input  cache_pkg::l2_tag_t             l2_tag3_rd,
    input  cache_pkg::plru_t               plru
);

    // staging registers
    cache_pkg::l2_index_t  index_q;
    cache_pkg::l1_tag_t    tag_q;

    logic                  access;
    logic                  addr_hit;
    logic                  addr_ro;
    logic                  is_fill;
    logic                  fill_l2;
    cache_pkg::way_t       fill_way;
    logic                  fill_bad;
    logic                  wr_ok;

    // no wait states
    assign pready = 1'b1;

    // second cycle of a transfer
    assign access = psel && penable;

    // address classification
    always_comb begin
        addr_hit = 1'b1;
        addr_ro  = 1'b0;
        case (paddr)
            cache_pkg::REG_INDEX,
            cache_pkg::REG_TAG_WD,
            cache_pkg::REG_FILL: addr_ro = 1'b0;
            cache_pkg::REG_L1_TAG0,
            cache_pkg::REG_L1_TAG1,
            cache_pkg::REG_L2_TAG0,
            cache_pkg::REG_L2_TAG1,
            cache_pkg::REG_L2_TAG2,
            cache_pkg::REG_L2_TAG3,
            cache_pkg::REG_REPL: addr_ro = 1'b1;
            default: addr_hit = 1'b0;
        endcase
    end

    // fill command fields, bit 0 level, bits 2..1 way
    assign is_fill  = pwrite && (paddr == cache_pkg::REG_FILL);
    assign fill_l2  = pwdata[0];
    assign fill_way = pwdata[2:1];
    // l1 has only ways 0 and 1
    assign fill_bad = is_fill && !fill_l2 && (fill_way >= cache_pkg::way_t'(cache_pkg::L1_WAYS));

    // error in the access cycle, nothing else happens then
    assign pslverr = access && (!addr_hit || (pwrite && addr_ro) || fill_bad);

    // accepted write this cycle
    assign wr_ok = access && pwrite && !pslverr;

    // one-hot way strobes, live only in the fill access cycle
    always_comb begin
        l1_we = '0;
        l2_we = '0;
        for (int w = 0; w < cache_pkg::L1_WAYS; w++) begin
            l1_we[w] = wr_ok && is_fill && !fill_l2 && (fill_way == cache_pkg::way_t'(w));
        end
        for (int w = 0; w < cache_pkg::L2_WAYS; w++) begin
            l2_we[w] = wr_ok && is_fill && fill_l2 && (fill_way == cache_pkg::way_t'(w));
        end
    end

    // index and tag staging
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index_q <= '0;
            tag_q   <= '0;
        end else if (wr_ok) begin
            if (paddr == cache_pkg::REG_INDEX) begin
                index_q <= pwdata[$bits(cache_pkg::l2_index_t)-1:0];
            end
            if (paddr == cache_pkg::REG_TAG_WD) begin
                tag_q <= pwdata[$bits(cache_pkg::l1_tag_t)-1:0];
            end
        end
    end

    // l1 sees the low index bits, l2 the low tag bits
    assign l1_index  = index_q[$bits(cache_pkg::l1_index_t)-1:0];
    assign l2_index  = index_q;
    assign l1_tag_wd = tag_q;
    assign l2_tag_wd = tag_q[$bits(cache_pkg::l2_tag_t)-1:0];

    // read mux, fill register and unmapped read as zero
    always_comb begin
        prdata = '0;
        case (paddr)
            cache_pkg::REG_INDEX:   prdata = cache_pkg::apb_data_t'(index_q);
            cache_pkg::REG_TAG_WD:  prdata = cache_pkg::apb_data_t'(tag_q);
            cache_pkg::REG_L1_TAG0: prdata = cache_pkg::apb_data_t'(l1_tag0_rd);
            cache_pkg::REG_L1_TAG1: prdata = cache_pkg::apb_data_t'(l1_tag1_rd);
            cache_pkg::REG_L2_TAG0: prdata = cache_pkg::apb_data_t'(l2_tag0_rd);
            cache_pkg::REG_L2_TAG1: prdata = cache_pkg::apb_data_t'(l2_tag1_rd);
            cache_pkg::REG_L2_TAG2: prdata = cache_pkg::apb_data_t'(l2_tag2_rd);
            cache_pkg::REG_L2_TAG3: prdata = cache_pkg::apb_data_t'(l2_tag3_rd);
            // lru in bit 0, tree bits above it
            cache_pkg::REG_REPL:    prdata = cache_pkg::apb_data_t'({plru, lru});
            default:                prdata = '0;
        endcase
    end

    // access phase is always preceded by a selected cycle
    a_setup_first : assert property (
        @(posedge clk) disable iff (!rst_n) penable |-> $past(psel)
    ) else $error("tag_apb_regs: penable without prior psel");

endmodule

`default_nettype wire

/* l2_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_tag_store (
    input  logic                           clk,
    input  cache_pkg::l2_index_t           index,
    input  logic [cache_pkg::L2_WAYS-1:0]  we,
    input  cache_pkg::l2_tag_t             tag_wd,
    output cache_pkg::l2_tag_t             tag0_rd,
    output cache_pkg::l2_tag_t             tag1_rd,
    output cache_pkg::l2_tag_t             tag2_rd,
    output cache_pkg::l2_tag_t             tag3_rd,
    output cache_pkg::plru_t               plru
);

    logic              plru_we;
    cache_pkg::plru_t  plru_wd;

    // tree write follows any way fill
    assign plru_we = |we;

    // next tree value from the current one and the filled way
    always_comb begin
        plru_wd = plru;
        if (we[0]) begin
            plru_wd = {plru[2], 2'b11};
        end else if (we[1]) begin
            plru_wd = {plru[2], 2'b01};
        end else if (we[2]) begin
            plru_wd = {1'b1, plru[1], 1'b0};
        end else if (we[3]) begin
            plru_wd = {1'b0, plru[1], 1'b0};
        end
    end

    // way 0 tags
    tag_sram #(
        .DEPTH (cache_pkg::L2_SETS),
        .WIDTH ($bits(cache_pkg::l2_tag_t))
    ) u_way0 (
        .clk  (clk),
        .addr (index),
        .we   (we[0]),
        .wd   (tag_wd),
        .rd   (tag0_rd)
    );

    // way 1 tags
    tag_sram #(
        .DEPTH (cache_pkg::L2_SETS),
        .WIDTH ($bits(cache_pkg::l2_tag_t))
    ) u_way1 (
        .clk  (clk),
        .addr (index),
        .we   (we[1]),
        .wd   (tag_wd),
        .rd   (tag1_rd)
    );

    // way 2 tags
    tag_sram #(
        .DEPTH (cache_pkg::L2_SETS),
        .WIDTH ($bits(cache_pkg::l2_tag_t))
    ) u_way2 (
        .clk  (clk),
        .addr (index),
        .we   (we[2]),
        .wd   (tag_wd),
        .rd   (tag2_rd)
    );

    // way 3 tags
    tag_sram #(
        .DEPTH (cache_pkg::L2_SETS),
        .WIDTH ($bits(cache_pkg::l2_tag_t))
    ) u_way3 (
        .clk  (clk),
        .addr (index),
        .we   (we[3]),
        .wd   (tag_wd),
        .rd   (tag3_rd)
    );

    // three tree bits per set
    tag_sram #(
        .DEPTH (cache_pkg::L2_SETS),
        .WIDTH ($bits(cache_pkg::plru_t))
    ) u_plru (
        .clk  (clk),
        .addr (index),
        .we   (plru_we),
        .wd   (plru_wd),
        .rd   (plru)
    );

    // fill decode upstream is one-hot or idle
    a_we_onehot : assert property (@(posedge clk) $onehot0(we))
        else $error("l2_tag_store: more than one way strobe high");

endmodule

`default_nettype wire

/* l1_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module l1_tag_store (
    input  logic                           clk,
    input  cache_pkg::l1_index_t           index,
    input  logic [cache_pkg::L1_WAYS-1:0]  we,
    input  cache_pkg::l1_tag_t             tag_wd,
    output cache_pkg::l1_tag_t             tag0_rd,
    output cache_pkg::l1_tag_t             tag1_rd,
    output logic                           lru
);

    logic lru_we;
    logic lru_wd;

    // lru updates together with any tag fill
    assign lru_we = |we;
    // fill of way 0 points lru at way 1, fill of way 1 points back at 0
    assign lru_wd = we[0];

    // way 0 tags
    tag_sram #(
        .DEPTH (cache_pkg::L1_SETS),
        .WIDTH ($bits(cache_pkg::l1_tag_t))
    ) u_way0 (
        .clk  (clk),
        .addr (index),
        .we   (we[0]),
        .wd   (tag_wd),
        .rd   (tag0_rd)
    );

    // way 1 tags
    tag_sram #(
        .DEPTH (cache_pkg::L1_SETS),
        .WIDTH ($bits(cache_pkg::l1_tag_t))
    ) u_way1 (
        .clk  (clk),
        .addr (index),
        .we   (we[1]),
        .wd   (tag_wd),
        .rd   (tag1_rd)
    );

    // one lru bit per set
    tag_sram #(
        .DEPTH (cache_pkg::L1_SETS),
        .WIDTH (1)
    ) u_lru (
        .clk  (clk),
        .addr (index),
        .we   (lru_we),
        .wd   (lru_wd),
        .rd   (lru)
    );

    // the register block never fills both ways in one cycle
    a_we_excl : assert property (@(posedge clk) !(we[0] && we[1]))
        else $error("l1_tag_store: both way strobes high");

endmodule

`default_nettype wire

/* tag_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_sram #(
    parameter int DEPTH = 256,
    parameter int WIDTH = 21
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic                     we,
    input  logic [WIDTH-1:0]         wd,
    output logic [WIDTH-1:0]         rd
);

    logic [WIDTH-1:0] mem [DEPTH];

    // all entries start at zero
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // read is asynchronous to the clock
    assign rd = mem[addr];

    // single write port
    always @(posedge clk) begin
        if (we) begin
            mem[addr] <= wd;
        end
    end

    // strobe from the bus side must be clean at every edge
    a_we_known : assert property (@(posedge clk) !$isunknown(we))
        else $error("tag_sram: write enable unknown");

endmodule

`default_nettype wire

/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // cache geometry
    localparam int L1_WAYS = 2;
    localparam int L1_SETS = 256;
    localparam int L2_WAYS = 4;
    localparam int L2_SETS = 512;

    // set index of each level
    typedef logic [$clog2(L1_SETS)-1:0] l1_index_t;
    typedef logic [$clog2(L2_SETS)-1:0] l2_index_t;

    // tag words, opaque to the store (valid/dirty live inside)
    typedef logic [20:0] l1_tag_t;
    typedef logic [18:0] l2_tag_t;

    // l2 tree pseudo-lru bits, numbered 2..0
    typedef logic [2:0] plru_t;

    // way number as carried in the fill command
    typedef logic [1:0] way_t;

    // apb bus fields
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // register map
    localparam apb_addr_t REG_INDEX   = 8'h00;
    localparam apb_addr_t REG_TAG_WD  = 8'h04;
    localparam apb_addr_t REG_FILL    = 8'h08;
    localparam apb_addr_t REG_L1_TAG0 = 8'h10;
    localparam apb_addr_t REG_L1_TAG1 = 8'h14;
    localparam apb_addr_t REG_L2_TAG0 = 8'h20;
    localparam apb_addr_t REG_L2_TAG1 = 8'h24;
    localparam apb_addr_t REG_L2_TAG2 = 8'h28;
    localparam apb_addr_t REG_L2_TAG3 = 8'h2c;
    localparam apb_addr_t REG_REPL    = 8'h30;

endpackage

`default_nettype wire
